/* src/sensio_pkg.sv */
// Shared constants of the sensor port control path.
// Control and JTAG fields are bit pairs: value at the listed position,
// enable one bit above it. Enable 0 keeps the register unchanged.
`default_nettype none

package sensio_pkg;

    // command port
    localparam int CMD_BYTES     = 6;  // AL, AH, D0..D3
    localparam int CMD_ADDR_BITS = 16;
    localparam int LOC_ADDR_BITS = 3;  // offset inside the sensor block
    localparam int DATA_BITS     = 32;

    // local register offsets, 4..7 unused
    localparam logic [LOC_ADDR_BITS-1:0] SENSIO_CTRL   = 3'd0;
    localparam logic [LOC_ADDR_BITS-1:0] SENSIO_STATUS = 3'd1;
    localparam logic [LOC_ADDR_BITS-1:0] SENSIO_JTAG   = 3'd2;
    localparam logic [LOC_ADDR_BITS-1:0] SENSIO_WIDTH  = 3'd3;

    // control word value bits
    localparam int CTRL_MRST = 0;
    localparam int CTRL_ARST = 2;
    localparam int CTRL_ARO  = 4;

    // JTAG word value bits
    localparam int JTAG_PGMEN = 8;
    localparam int JTAG_PROG  = 6;
    localparam int JTAG_TCK   = 4;
    localparam int JTAG_TMS   = 2;
    localparam int JTAG_TDI   = 0;

    // status packet
    localparam int STATUS_PAYLOAD_BITS = 6;
    localparam int STATUS_SEQ_BITS     = 6;  // mode sits right above the sequence
    localparam logic [1:0] STATUS_MODE_AUTO = 2'd3;  // resend on payload change
    localparam logic [1:0] STATUS_MODE_ONCE = 2'd2;  // 0 and 1 are stopped

endpackage

`default_nettype wire

/* src/sensio_cmd_deser.sv */
// Six-byte serial command receiver: AL, AH, then D0..D3 LSB first.
// cmd_stb_i marks the first byte, the rest follow back to back.
// Commands must be at least CMD_BYTES cycles apart.
`timescale 1ns/1ns
`default_nettype none

module sensio_cmd_deser #(
    parameter logic [sensio_pkg::CMD_ADDR_BITS-1:0] SENSIO_ADDR      = 'h330,
    parameter logic [sensio_pkg::CMD_ADDR_BITS-1:0] SENSIO_ADDR_MASK = 'h7f8
) (
    input  logic                                 mclk,
    input  logic                                 rst_i,
    input  logic [7:0]                           cmd_ad_i,
    input  logic                                 cmd_stb_i,
    output logic [sensio_pkg::LOC_ADDR_BITS-1:0] cmd_addr_o,
    output logic [sensio_pkg::DATA_BITS-1:0]     cmd_data_o,
    output logic                                 cmd_we_o
);

    localparam int SR_BITS  = 8 * sensio_pkg::CMD_BYTES;
    localparam int POS_BITS = $clog2(sensio_pkg::CMD_BYTES);
    localparam logic [POS_BITS-1:0] LAST_POS = POS_BITS'(sensio_pkg::CMD_BYTES - 1);

    logic [SR_BITS-1:0]                   sr;        // newest byte enters at the top
    logic [POS_BITS-1:0]                  pos_r;     // byte position, 0 when idle
    logic                                 last_r;    // all bytes are in
    logic [sensio_pkg::CMD_ADDR_BITS-1:0] full_addr;
    logic                                 addr_hit;

    assign full_addr = sr[sensio_pkg::CMD_ADDR_BITS-1:0];
    assign addr_hit  = ((full_addr ^ SENSIO_ADDR) & SENSIO_ADDR_MASK) == '0;

    always_ff @(posedge mclk) begin
        if (cmd_stb_i || pos_r != '0) begin
            sr <= {cmd_ad_i, sr[SR_BITS-1:8]};  // shift right, LSB byte ends lowest
        end
        if (last_r) begin  // hold words through the write pulse
            cmd_addr_o <= full_addr[sensio_pkg::LOC_ADDR_BITS-1:0];
            cmd_data_o <= sr[SR_BITS-1:sensio_pkg::CMD_ADDR_BITS];
        end
    end

    always_ff @(posedge mclk or posedge rst_i) begin
        if (rst_i) begin
            pos_r    <= '0;
            last_r   <= 1'b0;
            cmd_we_o <= 1'b0;
        end else begin
            last_r   <= (pos_r == LAST_POS);
            cmd_we_o <= last_r && addr_hit;  // foreign commands are dropped here
            if (cmd_stb_i) begin
                pos_r <= POS_BITS'(1);  // first byte taken with the strobe
            end else if (pos_r == LAST_POS) begin
                pos_r <= '0;
            end else if (pos_r != '0) begin
                pos_r <= pos_r + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/sensio_decode.sv */
// Register write decode: latches the command word and issues one
// single-cycle strobe per write, one cycle after cmd_we_i.
// Offsets 4..7 are ignored.
`timescale 1ns/1ns
`default_nettype none

module sensio_decode (
    input  logic                                 mclk,
    input  logic                                 rst_i,
    input  logic [sensio_pkg::LOC_ADDR_BITS-1:0] cmd_addr_i,
    input  logic [sensio_pkg::DATA_BITS-1:0]     cmd_data_i,
    input  logic                                 cmd_we_i,
    output logic [sensio_pkg::DATA_BITS-1:0]     data_o,
    output logic                                 set_ctrl_o,
    output logic                                 set_jtag_o,
    output logic                                 set_width_o,
    output logic                                 set_status_o
);

    always_ff @(posedge mclk) begin
        if (cmd_we_i) begin
            data_o <= cmd_data_i;  // shared by all register blocks
        end
    end

    always_ff @(posedge mclk or posedge rst_i) begin
        if (rst_i) begin
            set_ctrl_o   <= 1'b0;
            set_jtag_o   <= 1'b0;
            set_width_o  <= 1'b0;
            set_status_o <= 1'b0;
        end else begin
            set_ctrl_o   <= cmd_we_i && (cmd_addr_i == sensio_pkg::SENSIO_CTRL);
            set_jtag_o   <= cmd_we_i && (cmd_addr_i == sensio_pkg::SENSIO_JTAG);
            set_width_o  <= cmd_we_i && (cmd_addr_i == sensio_pkg::SENSIO_WIDTH);
            set_status_o <= cmd_we_i && (cmd_addr_i == sensio_pkg::SENSIO_STATUS);
        end
    end

endmodule

`default_nettype wire

/* src/sensio_ctrl_regs.sv */
// Sensor reset/trigger bits and the bit-banged JTAG port.
// In programming mode (xpgmen) ARO/ARST carry TCK/TMS, MRST turns input
// to read DONE and SENSPGM drives PROG_B. trig_i and senspgm_i must be
// synchronous to mclk.
`timescale 1ns/1ns
`default_nettype none

module sensio_ctrl_regs (
    input  logic                             mclk,
    input  logic                             rst_i,
    input  logic                             set_ctrl_i,
    input  logic                             set_jtag_i,
    input  logic [sensio_pkg::DATA_BITS-1:0] data_i,
    input  logic                             trigger_mode_i,  // 0 = free running
    input  logic                             trig_i,
    input  logic                             senspgm_i,       // SENSPGM pin level
    output logic                             aro_o,
    output logic                             arst_o,
    output logic                             mrst_o,
    output logic                             mrst_oe_o,
    output logic                             senspgm_o,
    output logic                             senspgm_oe_o,
    output logic                             tdi_o,
    output logic                             tdi_oe_o,
    output logic                             xpgmen_o,
    output logic                             force_senspgm_o
);

    logic imrst;
    logic iarst;
    logic aro_soft;
    logic xpgmen;
    logic prog;      // PROG_B level before inversion
    logic tck;
    logic tms;
    logic tdi;
    logic xpgmen_d;  // for falling edge of xpgmen
    logic force_senspgm;

    always_ff @(posedge mclk or posedge rst_i) begin
        if (rst_i) begin
            imrst         <= 1'b0;
            iarst         <= 1'b0;
            aro_soft      <= 1'b0;
            xpgmen        <= 1'b0;
            prog          <= 1'b0;
            tck           <= 1'b0;
            tms           <= 1'b0;
            tdi           <= 1'b0;
            xpgmen_d      <= 1'b0;
            force_senspgm <= 1'b0;
        end else begin
            // control word, each value bit guarded by the bit above it
            if (set_ctrl_i && data_i[sensio_pkg::CTRL_MRST+1]) imrst <= data_i[sensio_pkg::CTRL_MRST];
            if (set_ctrl_i && data_i[sensio_pkg::CTRL_ARST+1]) iarst <= data_i[sensio_pkg::CTRL_ARST];
            if (set_ctrl_i && data_i[sensio_pkg::CTRL_ARO+1]) aro_soft <= data_i[sensio_pkg::CTRL_ARO];
            // JTAG word
            if (set_jtag_i && data_i[sensio_pkg::JTAG_PGMEN+1]) xpgmen <= data_i[sensio_pkg::JTAG_PGMEN];
            if (set_jtag_i && data_i[sensio_pkg::JTAG_PROG+1]) prog <= data_i[sensio_pkg::JTAG_PROG];
            if (set_jtag_i && data_i[sensio_pkg::JTAG_TCK+1]) tck <= data_i[sensio_pkg::JTAG_TCK];
            if (set_jtag_i && data_i[sensio_pkg::JTAG_TMS+1]) tms <= data_i[sensio_pkg::JTAG_TMS];
            if (set_jtag_i && data_i[sensio_pkg::JTAG_TDI+1]) tdi <= data_i[sensio_pkg::JTAG_TDI];
            xpgmen_d <= xpgmen;
            if (xpgmen_d && !xpgmen) begin
                force_senspgm <= senspgm_i;  // probe pin once programming ends
            end
        end
    end

    // pin multiplexing
    assign aro_o     = xpgmen ? tck : (trigger_mode_i ? ~trig_i : aro_soft);
    assign arst_o    = xpgmen ? tms : iarst;
    assign mrst_o    = imrst;
    assign mrst_oe_o = ~xpgmen;  // released to read DONE
    assign tdi_o     = tdi;
    assign tdi_oe_o  = xpgmen;

    assign senspgm_o    = xpgmen ? ~prog : force_senspgm;
    assign senspgm_oe_o = xpgmen | force_senspgm;

    assign xpgmen_o        = xpgmen;
    assign force_senspgm_o = force_senspgm;

endmodule

`default_nettype wire

/* src/sensio_hact_regen.sv */
// HACT pass-through or regeneration at a fixed line width.
// Width 0 follows hact_i; width N > 0 gives N-cycle pulses per rising
// edge. hact_i must be synchronous to mclk. Follow mode after reset.
`timescale 1ns/1ns
`default_nettype none

module sensio_hact_regen #(
    parameter int LINE_WIDTH_BITS = 16
) (
    input  logic                             mclk,
    input  logic                             rst_i,
    input  logic                             set_width_i,
    input  logic [sensio_pkg::DATA_BITS-1:0] data_i,
    input  logic                             hact_i,
    output logic                             hact_o
);

    logic [LINE_WIDTH_BITS-1:0] width_m1_r;  // line width minus one
    logic                       regen_r;     // cleared when width is zero
    logic [LINE_WIDTH_BITS-1:0] cntr_r;
    logic                       hact_r;      // registered input
    logic                       hact_d;
    logic                       hact_rise;
    logic                       line_end;

    assign hact_rise = hact_r && !hact_d;
    assign line_end  = regen_r ? (cntr_r == '0) : !hact_r;

    always_ff @(posedge mclk or posedge rst_i) begin
        if (rst_i) begin
            width_m1_r <= '0;
            regen_r    <= 1'b0;
            cntr_r     <= '0;
            hact_r     <= 1'b0;
            hact_d     <= 1'b0;
            hact_o     <= 1'b0;
        end else begin
            if (set_width_i) begin
                width_m1_r <= data_i[LINE_WIDTH_BITS-1:0] - 1'b1;
                regen_r    <= |data_i[LINE_WIDTH_BITS-1:0];
            end
            hact_r <= hact_i;
            hact_d <= hact_r;
            if (hact_rise) begin
                hact_o <= 1'b1;
                cntr_r <= width_m1_r;  // a new edge restarts the line
            end else begin
                if (line_end) hact_o <= 1'b0;
                if (hact_o && cntr_r != '0) cntr_r <= cntr_r - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/sensio_status_gen.sv */
// Status packet source: STATUS_REG_ADDR, {seq, payload[1:0]},
// {4'b0, payload[5:2]}. Payload is captured on status_start_i, which
// may come any time after status_rq_o rises. Control word: seq in
// the low bits, 2-bit mode right above.
`timescale 1ns/1ns
`default_nettype none

module sensio_status_gen #(
    parameter logic [7:0] STATUS_REG_ADDR = 'h31
) (
    input  logic                                       mclk,
    input  logic                                       rst_i,
    input  logic                                       set_status_i,
    input  logic [sensio_pkg::DATA_BITS-1:0]           data_i,
    input  logic [sensio_pkg::STATUS_PAYLOAD_BITS-1:0] status_i,
    input  logic                                       status_start_i,
    output logic [7:0]                                 status_ad_o,
    output logic                                       status_rq_o
);

    localparam int SEQ_BITS = sensio_pkg::STATUS_SEQ_BITS;
    localparam int PL_BITS  = sensio_pkg::STATUS_PAYLOAD_BITS;

    logic [1:0]          mode_r;
    logic [SEQ_BITS-1:0] seq_r;
    logic [PL_BITS-1:0]  sent_r;   // payload of the last packet
    logic [1:0]          phase_r;  // bytes 1 and 2 after start
    logic [1:0]          wr_mode;
    logic                changed;

    assign wr_mode = data_i[SEQ_BITS +: 2];
    assign changed = (mode_r == sensio_pkg::STATUS_MODE_AUTO) && (status_i != sent_r);

    always_ff @(posedge mclk or posedge rst_i) begin
        if (rst_i) begin
            mode_r      <= '0;
            seq_r       <= '0;
            sent_r      <= '0;
            phase_r     <= '0;
            status_rq_o <= 1'b0;
        end else begin
            if (set_status_i) begin
                mode_r <= wr_mode;
                seq_r  <= data_i[SEQ_BITS-1:0];
            end
            phase_r <= {phase_r[0], status_start_i};
            if (status_start_i) begin
                sent_r      <= status_i;  // snapshot for bytes 1, 2 and change detect
                status_rq_o <= 1'b0;
            end else if (set_status_i) begin
                status_rq_o <= (wr_mode == sensio_pkg::STATUS_MODE_ONCE) ||
                               (wr_mode == sensio_pkg::STATUS_MODE_AUTO);  // stop drops it
            end else if (changed) begin
                status_rq_o <= 1'b1;
            end
        end
    end

    always_comb begin
        if (status_start_i) begin
            status_ad_o = STATUS_REG_ADDR;
        end else if (phase_r[0]) begin
            status_ad_o = {seq_r, sent_r[1:0]};
        end else if (phase_r[1]) begin
            status_ad_o = 8'(sent_r[PL_BITS-1:2]);  // upper nibble zero
        end else begin
            status_ad_o = '0;
        end
    end

endmodule

`default_nettype wire

/* src/sensio_top.sv */
// Control path of the 12-bit parallel sensor port, all on mclk.
// Pad inputs, hact_i and trig_i must already be synchronous to mclk.
// Register pins change 3 cycles after the last command byte.
`timescale 1ns/1ns
`default_nettype none

module sensio_top #(
    parameter logic [sensio_pkg::CMD_ADDR_BITS-1:0] SENSIO_ADDR      = 'h330,
    parameter logic [sensio_pkg::CMD_ADDR_BITS-1:0] SENSIO_ADDR_MASK = 'h7f8,
    parameter int                                   LINE_WIDTH_BITS  = 16,
    parameter logic [7:0]                           STATUS_REG_ADDR  = 'h31
) (
    input  logic       mclk,
    input  logic       rst_i,
    input  logic [7:0] cmd_ad_i,
    input  logic       cmd_stb_i,
    input  logic       status_start_i,
    input  logic       trigger_mode_i,
    input  logic       trig_i,
    input  logic       hact_i,
    input  logic       mrst_i,     // MRST pad, DONE in programming mode
    input  logic       senspgm_i,
    input  logic       tdo_i,
    output logic [7:0] status_ad_o,
    output logic       status_rq_o,
    output logic       aro_o,
    output logic       arst_o,
    output logic       mrst_o,
    output logic       mrst_oe_o,
    output logic       senspgm_o,
    output logic       senspgm_oe_o,
    output logic       tdi_o,
    output logic       tdi_oe_o,
    output logic       hact_o
);

    logic [sensio_pkg::LOC_ADDR_BITS-1:0]       cmd_addr;
    logic [sensio_pkg::DATA_BITS-1:0]           cmd_data;
    logic                                       cmd_we;
    logic [sensio_pkg::DATA_BITS-1:0]           data_r;
    logic                                       set_ctrl;
    logic                                       set_jtag;
    logic                                       set_width;
    logic                                       set_status;
    logic                                       xpgmen;
    logic                                       force_senspgm;
    logic [sensio_pkg::STATUS_PAYLOAD_BITS-1:0] status;

    assign status = {xpgmen, force_senspgm, hact_o, mrst_i, tdo_i, senspgm_i};

    sensio_cmd_deser #(
        .SENSIO_ADDR      (SENSIO_ADDR),
        .SENSIO_ADDR_MASK (SENSIO_ADDR_MASK)
    ) cmd_deser_i (
        .mclk       (mclk),
        .rst_i      (rst_i),
        .cmd_ad_i   (cmd_ad_i),
        .cmd_stb_i  (cmd_stb_i),
        .cmd_addr_o (cmd_addr),
        .cmd_data_o (cmd_data),
        .cmd_we_o   (cmd_we)
    );

    sensio_decode decode_i (
        .mclk         (mclk),
        .rst_i        (rst_i),
        .cmd_addr_i   (cmd_addr),
        .cmd_data_i   (cmd_data),
        .cmd_we_i     (cmd_we),
        .data_o       (data_r),
        .set_ctrl_o   (set_ctrl),
        .set_jtag_o   (set_jtag),
        .set_width_o  (set_width),
        .set_status_o (set_status)
    );

    sensio_ctrl_regs ctrl_regs_i (
        .mclk            (mclk),
        .rst_i           (rst_i),
        .set_ctrl_i      (set_ctrl),
        .set_jtag_i      (set_jtag),
        .data_i          (data_r),
        .trigger_mode_i  (trigger_mode_i),
        .trig_i          (trig_i),
        .senspgm_i       (senspgm_i),
        .aro_o           (aro_o),
        .arst_o          (arst_o),
        .mrst_o          (mrst_o),
        .mrst_oe_o       (mrst_oe_o),
        .senspgm_o       (senspgm_o),
        .senspgm_oe_o    (senspgm_oe_o),
        .tdi_o           (tdi_o),
        .tdi_oe_o        (tdi_oe_o),
        .xpgmen_o        (xpgmen),
        .force_senspgm_o (force_senspgm)
    );

    sensio_hact_regen #(
        .LINE_WIDTH_BITS (LINE_WIDTH_BITS)
    ) hact_regen_i (
        .mclk        (mclk),
        .rst_i       (rst_i),
        .set_width_i (set_width),
        .data_i      (data_r),
        .hact_i      (hact_i),
        .hact_o      (hact_o)
    );

    sensio_status_gen #(
        .STATUS_REG_ADDR (STATUS_REG_ADDR)
    ) status_gen_i (
        .mclk           (mclk),
        .rst_i          (rst_i),
        .set_status_i   (set_status),
        .data_i         (data_r),
        .status_i       (status),
        .status_start_i (status_start_i),
        .status_ad_o    (status_ad_o),
        .status_rq_o    (status_rq_o)
    );

endmodule

`default_nettype wire

/* verification/tb_sensio.sv */
// Self-checking testbench for sensio_top.
// A command table covers the control and JTAG registers. HACT and status
// packet tests follow. Inputs change on the falling mclk edge. Outputs are
// sampled at the falling edge, or 1 ns after it for combinational paths.
`timescale 1ns/1ns
`default_nettype none

module tb_sensio;

    localparam logic [15:0] BASE_ADDR  = 16'h0330;
    localparam logic [15:0] ADDR_MASK  = 16'h07f8;
    localparam int          WIDTH_BITS = 16;
    localparam logic [7:0]  STAT_ADDR  = 8'h31;
    localparam int          TBL_SIZE   = 20;
    localparam logic [31:0] SEED       = 32'hf9e14f6d;

    logic       mclk = 1'b0;
    logic       rst_i;
    logic [7:0] cmd_ad_i;
    logic       cmd_stb_i;
    logic       status_start_i;
    logic       trigger_mode_i;
    logic       trig_i;
    logic       hact_i;
    logic       mrst_i;
    logic       senspgm_i;
    logic       tdo_i;
    logic [7:0] status_ad_o;
    logic       status_rq_o;
    logic       aro_o;
    logic       arst_o;
    logic       mrst_o;
    logic       mrst_oe_o;
    logic       senspgm_o;
    logic       senspgm_oe_o;
    logic       tdi_o;
    logic       tdi_oe_o;
    logic       hact_o;

    // command table
    // expected pins as {aro, arst, mrst, mrst_oe, senspgm, senspgm_oe, tdi, tdi_oe}
    logic [15:0] tbl_addr [TBL_SIZE];
    logic [31:0] tbl_data [TBL_SIZE];
    logic        tbl_pgm  [TBL_SIZE];  // senspgm_i level during the write
    logic [7:0]  tbl_exp  [TBL_SIZE];
    int          tbl_len;

    // register model
    logic m_mrst;
    logic m_arst;
    logic m_aro;
    logic m_pgmen;
    logic m_prog;
    logic m_tck;
    logic m_tms;
    logic m_tdi;
    logic m_force;

    logic [31:0] rng;
    int          checks;
    int          errors;

    always #10 mclk = ~mclk;  // 20 ns period

    sensio_top #(
        .SENSIO_ADDR      (BASE_ADDR),
        .SENSIO_ADDR_MASK (ADDR_MASK),
        .LINE_WIDTH_BITS  (WIDTH_BITS),
        .STATUS_REG_ADDR  (STAT_ADDR)
    ) dut_i (
        .mclk           (mclk),
        .rst_i          (rst_i),
        .cmd_ad_i       (cmd_ad_i),
        .cmd_stb_i      (cmd_stb_i),
        .status_start_i (status_start_i),
        .trigger_mode_i (trigger_mode_i),
        .trig_i         (trig_i),
        .hact_i         (hact_i),
        .mrst_i         (mrst_i),
        .senspgm_i      (senspgm_i),
        .tdo_i          (tdo_i),
        .status_ad_o    (status_ad_o),
        .status_rq_o    (status_rq_o),
        .aro_o          (aro_o),
        .arst_o         (arst_o),
        .mrst_o         (mrst_o),
        .mrst_oe_o      (mrst_oe_o),
        .senspgm_o      (senspgm_o),
        .senspgm_oe_o   (senspgm_oe_o),
        .tdi_o          (tdi_o),
        .tdi_oe_o       (tdi_oe_o),
        .hact_o         (hact_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] model_pins();
        logic aro;
        logic arst;
        logic spgm;
        aro  = m_pgmen ? m_tck : m_aro;  // trigger mode off
        arst = m_pgmen ? m_tms : m_arst;
        spgm = m_pgmen ? ~m_prog : m_force;
        return {aro, arst, m_mrst, ~m_pgmen, spgm, m_pgmen | m_force, m_tdi, m_pgmen};
    endfunction

    function automatic logic [5:0] model_payload();
        return {m_pgmen, m_force, 1'b0, mrst_i, tdo_i, senspgm_i};  // hact idle here
    endfunction

    function automatic logic [31:0] status_word(input logic [1:0] mode, input logic [5:0] seq);
        return (32'(mode) << sensio_pkg::STATUS_SEQ_BITS) | 32'(seq);
    endfunction

    // control word that inverts every field of the model if it is accepted
    function automatic logic [31:0] flip_ctrl_word();
        logic [31:0] w;
        w = '0;
        w[sensio_pkg::CTRL_MRST +: 2] = {1'b1, ~m_mrst};
        w[sensio_pkg::CTRL_ARST +: 2] = {1'b1, ~m_arst};
        w[sensio_pkg::CTRL_ARO +: 2]  = {1'b1, ~m_aro};
        return w;
    endfunction

    task automatic model_write(input logic [15:0] addr, input logic [31:0] data, input logic pgm);
        logic was_pgm;
        was_pgm = m_pgmen;
        if (((addr ^ BASE_ADDR) & ADDR_MASK) == 16'h0) begin
            if (addr[2:0] == sensio_pkg::SENSIO_CTRL) begin
                if (data[sensio_pkg::CTRL_MRST + 1]) m_mrst = data[sensio_pkg::CTRL_MRST];
                if (data[sensio_pkg::CTRL_ARST + 1]) m_arst = data[sensio_pkg::CTRL_ARST];
                if (data[sensio_pkg::CTRL_ARO + 1]) m_aro = data[sensio_pkg::CTRL_ARO];
            end else if (addr[2:0] == sensio_pkg::SENSIO_JTAG) begin
                if (data[sensio_pkg::JTAG_PGMEN + 1]) m_pgmen = data[sensio_pkg::JTAG_PGMEN];
                if (data[sensio_pkg::JTAG_PROG + 1]) m_prog = data[sensio_pkg::JTAG_PROG];
                if (data[sensio_pkg::JTAG_TCK + 1]) m_tck = data[sensio_pkg::JTAG_TCK];
                if (data[sensio_pkg::JTAG_TMS + 1]) m_tms = data[sensio_pkg::JTAG_TMS];
                if (data[sensio_pkg::JTAG_TDI + 1]) m_tdi = data[sensio_pkg::JTAG_TDI];
            end
        end
        if (was_pgm && !m_pgmen) m_force = pgm;  // pin probed when programming ends
    endtask

    task automatic add_entry(input logic [15:0] addr, input logic [31:0] data, input logic pgm);
        tbl_addr[tbl_len] = addr;
        tbl_data[tbl_len] = data;
        tbl_pgm[tbl_len]  = pgm;
        model_write(addr, data, pgm);
        tbl_exp[tbl_len]  = model_pins();
        tbl_len++;
    endtask

    task automatic fill_table();
        int i;
        for (i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            add_entry(BASE_ADDR, rng, 1'b0);  // random control words
        end
        add_entry(16'h0338, flip_ctrl_word(), 1'b0);  // dropped on bit 3
        add_entry(16'h0730, flip_ctrl_word(), 1'b0);  // dropped on bit 10
        add_entry(16'h1330, flip_ctrl_word(), 1'b0);  // bit 12 lies outside the mask
        add_entry(16'h0334, flip_ctrl_word(), 1'b0);  // offset 4 unused
        add_entry(16'h0332, 32'h0000_03fb, 1'b0);  // enter programming
        rng = xorshift32(rng);
        add_entry(16'h0332, 32'h300 | {24'h0, rng[7:0]}, 1'b0);
        rng = xorshift32(rng);
        add_entry(16'h0332, 32'h300 | {24'h0, rng[7:0]}, 1'b0);
        add_entry(16'h0332, 32'h0000_0200, 1'b0);  // leave with pin low
        add_entry(16'h0332, 32'h0000_0300, 1'b1);
        add_entry(16'h0332, 32'h0000_0200, 1'b1);  // leave with pin high
        rng = xorshift32(rng);
        add_entry(BASE_ADDR, rng, 1'b1);
        rng = xorshift32(rng);
        add_entry(BASE_ADDR, rng, 1'b1);
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic abort_run(input string why);
        errors++;
        $display("%s at t=%0t", why, $time);
        finish_run();
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s got %0h exp %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_pins(input logic [7:0] exp);
        check_val("aro_o", aro_o, exp[7]);
        check_val("arst_o", arst_o, exp[6]);
        check_val("mrst_o", mrst_o, exp[5]);
        check_val("mrst_oe_o", mrst_oe_o, exp[4]);
        check_val("senspgm_o", senspgm_o, exp[3]);
        check_val("senspgm_oe_o", senspgm_oe_o, exp[2]);
        check_val("tdi_o", tdi_o, exp[1]);
        check_val("tdi_oe_o", tdi_oe_o, exp[0]);
    endtask

    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] bytes;
        int          i;
        bytes = {data, addr};  // AL first and D3 last
        for (i = 0; i < sensio_pkg::CMD_BYTES; i++) begin
            @(negedge mclk);
            cmd_stb_i = (i == 0);
            cmd_ad_i  = bytes[8*i +: 8];
        end
        @(negedge mclk);
        cmd_stb_i = 1'b0;
        cmd_ad_i  = 8'h00;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        send_cmd(addr, data);
        repeat (4) @(negedge mclk);  // pins settle 3 cycles after the last byte
    endtask

    task automatic wait_rq(input int limit);
        int n;
        n = 0;
        while (status_rq_o !== 1'b1 && n < limit) begin
            @(negedge mclk);
            n++;
        end
        if (status_rq_o !== 1'b1) abort_run("timeout waiting for status_rq_o");
    endtask

    task automatic read_packet(input logic [5:0] seq, input logic [5:0] pl, input int delay);
        wait_rq(20);
        repeat (delay) begin
            @(negedge mclk);
            check_val("status_rq_o", status_rq_o, 1'b1);  // held while start is late
        end
        @(negedge mclk);
        status_start_i = 1'b1;
        #1;
        check_val("status_ad_o", status_ad_o, STAT_ADDR);
        @(negedge mclk);
        status_start_i = 1'b0;
        #1;
        check_val("status_ad_o", status_ad_o, {seq, pl[1:0]});
        check_val("status_rq_o", status_rq_o, 1'b0);
        @(negedge mclk);
        #1;
        check_val("status_ad_o", status_ad_o, {4'h0, pl[5:2]});
        @(negedge mclk);
        #1;
        check_val("status_ad_o", status_ad_o, 8'h00);  // idle after byte 2
    endtask

    task automatic check_quiet();
        repeat (8) begin
            @(negedge mclk);
            check_val("status_rq_o", status_rq_o, 1'b0);
        end
    endtask

    task automatic check_hact_width(input int width);
        int high;
        int k;
        write_reg(BASE_ADDR + 16'(sensio_pkg::SENSIO_WIDTH), 32'(width));
        high   = 0;
        hact_i = 1'b1;
        for (k = 0; k < width + 12; k++) begin
            @(negedge mclk);
            if (k == 2) hact_i = 1'b0;  // 3-cycle input pulse
            if (hact_o === 1'b1) high++;
        end
        check_val("hact_o high cycles", high, width);
    endtask

    task automatic check_hact_follow();
        logic h1;
        logic h2;
        int   k;
        write_reg(BASE_ADDR + 16'(sensio_pkg::SENSIO_WIDTH), 32'h0);
        h1 = 1'b0;
        h2 = 1'b0;
        for (k = 0; k < 32; k++) begin
            @(negedge mclk);
            check_val("hact_o", hact_o, h2);  // input register plus output register
            h2     = h1;
            rng    = xorshift32(rng);
            hact_i = rng[0];
            h1     = hact_i;
        end
        @(negedge mclk);
        hact_i = 1'b0;
        repeat (4) @(negedge mclk);
    endtask

    task automatic status_tests();
        logic [5:0] seq;
        int         delay;
        rng   = xorshift32(rng);
        seq   = rng[5:0];
        delay = rng[11:8];
        @(negedge mclk);
        mrst_i = 1'b1;
        write_reg(BASE_ADDR + 16'(sensio_pkg::SENSIO_STATUS),
                  status_word(sensio_pkg::STATUS_MODE_ONCE, seq));
        read_packet(seq, model_payload(), delay);
        @(negedge mclk);
        tdo_i = ~tdo_i;
        check_quiet();  // once mode ignores changes
        rng = xorshift32(rng);
        seq = rng[5:0];
        write_reg(BASE_ADDR + 16'(sensio_pkg::SENSIO_STATUS),
                  status_word(sensio_pkg::STATUS_MODE_AUTO, seq));
        read_packet(seq, model_payload(), 0);
        @(negedge mclk);
        tdo_i = ~tdo_i;
        read_packet(seq, model_payload(), rng[15:12]);
        check_quiet();
        write_reg(BASE_ADDR + 16'(sensio_pkg::SENSIO_STATUS), status_word(2'd0, seq));
        @(negedge mclk);
        tdo_i = ~tdo_i;
        check_quiet();  // stopped
    endtask

    initial begin
        int i;
        rst_i          = 1'b1;
        cmd_ad_i       = 8'h00;
        cmd_stb_i      = 1'b0;
        status_start_i = 1'b0;
        trigger_mode_i = 1'b0;
        trig_i         = 1'b0;
        hact_i         = 1'b0;
        mrst_i         = 1'b0;
        senspgm_i      = 1'b0;
        tdo_i          = 1'b0;
        {m_mrst, m_arst, m_aro, m_pgmen, m_prog, m_tck, m_tms, m_tdi, m_force} = '0;
        checks  = 0;
        errors  = 0;
        tbl_len = 0;
        rng     = SEED;
        fill_table();
        repeat (3) @(negedge mclk);
        rst_i = 1'b0;
        @(negedge mclk);
        check_pins(8'b0001_0000);  // only mrst_oe set
        check_val("hact_o", hact_o, 1'b0);
        check_val("status_rq_o", status_rq_o, 1'b0);
        check_val("status_ad_o", status_ad_o, 8'h00);

        for (i = 0; i < tbl_len; i++) begin
            senspgm_i = tbl_pgm[i];
            write_reg(tbl_addr[i], tbl_data[i]);
            check_pins(tbl_exp[i]);
        end

        trigger_mode_i = 1'b1;
        for (i = 0; i < 6; i++) begin
            @(negedge mclk);
            trig_i = ~trig_i;  // both levels seen
            #1;
            check_val("aro_o", aro_o, !trig_i);  // inverted trigger
        end
        @(negedge mclk);
        trigger_mode_i = 1'b0;
        #1;
        check_val("aro_o", aro_o, m_aro);

        check_hact_width(1);
        check_hact_width(7);
        rng = xorshift32(rng);
        check_hact_width(int'(rng % 39) + 2);
        check_hact_follow();

        status_tests();
        finish_run();
    end

endmodule

`default_nettype wire

/* flist.f */
src/sensio_pkg.sv
src/sensio_cmd_deser.sv
src/sensio_decode.sv
src/sensio_ctrl_regs.sv
src/sensio_hact_regen.sv
src/sensio_status_gen.sv
src/sensio_top.sv
verification/tb_sensio.sv

/* Bender.yml */
package:
  name: sensio

sources:
  - files:
      - src/sensio_pkg.sv
      - src/sensio_cmd_deser.sv
      - src/sensio_decode.sv
      - src/sensio_ctrl_regs.sv
      - src/sensio_hact_regen.sv
      - src/sensio_status_gen.sv
      - src/sensio_top.sv
  - target: simulation
    files:
      - verification/tb_sensio.sv
